//--- zports_consts.svh
// port addresses, xxAF register indices and reset values, included by RTL and testbench
`ifndef ZPORTS_CONSTS_SVH
`define ZPORTS_CONSTS_SVH

// low address byte of each decoded port
`define PORT_FE      8'hFE
`define PORT_XT      8'hAF
`define PORT_FD      8'hFD
`define PORT_SDCFG   8'h77
`define PORT_SDDAT   8'h57

// xxAF register index, taken from the high address byte
`define XT_XSTAT     8'h00
`define XT_RAMPAGE   8'h10 // covers 10..13
`define XT_SYSCONF   8'h20
`define XT_MEMCONF   8'h21
`define XT_IM2VECT   8'h25
`define XT_DMASTAT   8'h27

// reset values of the system registers
`define SYSCONF_RST  8'h01 // turbo 7 MHz
`define MEMCONF_RST  8'h04 // no map
`define IM2VECT_RST  8'hFF

// power-up page map, page 0 to 3
`define PAGE0_RST    8'h00
`define PAGE1_RST    8'h05
`define PAGE2_RST    8'h02
`define PAGE3_RST    8'h00

`endif

//--- zports_pkg.sv
// shared types of the port block, compiled before every module that uses them
package zports_pkg;

	// one byte on the Z80 data bus
	typedef logic [7:0] byte_t;

	// full 16-bit I/O address
	typedef logic [15:0] addr_t;

	// RAM page number
	typedef logic [7:0] page_t;

	// pages 3..0, page 3 in the top byte
	typedef logic [31:0] xt_page_t;

	// port decoded from the low address byte
	typedef enum logic [2:0] {
		PORT_NONE,
		PORT_FE,
		PORT_XT,
		PORT_7FFD,
		PORT_SDCFG,
		PORT_SDDAT
	} port_id_t;

	// one bus access, valid while wr or rd is high
	typedef struct packed {
		port_id_t port;
		byte_t    xt_index; // high address byte
		byte_t    data;     // write data
		logic     wr;
		logic     rd;
		logic     a15;
	} io_access_t;

endpackage

//--- zbus_access.sv
// bus access stage: turns the iowr and iord levels into decoded one-cycle access pulses
`include "zports_consts.svh"

module zbus_access (
	input  logic                   zclk,
	input  logic                   rst,
	input  zports_pkg::addr_t      a,
	input  zports_pkg::byte_t      din,
	input  logic                   iowr,
	input  logic                   iord,
	output zports_pkg::io_access_t acc
);

	logic wr_s, rd_s; // sampled levels
	logic wr_d, rd_d; // one cycle older
	logic wr_q, rd_q;

	zports_pkg::port_id_t port_d;
	zports_pkg::port_id_t port_q;
	zports_pkg::byte_t    hi_q;
	zports_pkg::byte_t    data_q;
	logic                 a15_q;

	// decode of the low address byte
	always_comb
	begin
		case (a[7:0])
			`PORT_FE:    port_d = zports_pkg::PORT_FE;
			`PORT_XT:    port_d = zports_pkg::PORT_XT;
			`PORT_FD:    port_d = a[15] ? zports_pkg::PORT_NONE : zports_pkg::PORT_7FFD; // AY when a15 set
			`PORT_SDCFG: port_d = zports_pkg::PORT_SDCFG;
			`PORT_SDDAT: port_d = zports_pkg::PORT_SDDAT;
			default:     port_d = zports_pkg::PORT_NONE;
		endcase
	end

	always_ff @(posedge zclk)
	begin
		if (rst)
		begin
			wr_s <= 1'b0;
			rd_s <= 1'b0;
			wr_d <= 1'b0;
			rd_d <= 1'b0;
			wr_q <= 1'b0;
			rd_q <= 1'b0;
		end
		else
		begin
			wr_s <= iowr;
			rd_s <= iord;
			wr_d <= wr_s;
			rd_d <= rd_s;
			wr_q <= wr_s & ~wr_d; // rising edge only
			rd_q <= rd_s & ~rd_d;
		end
	end

	// payload travels with the pulse
	always_ff @(posedge zclk)
	begin
		port_q <= port_d;
		hi_q   <= a[15:8];
		data_q <= din;
		a15_q  <= a[15];
	end

	assign acc = '{port: port_q, xt_index: hi_q, data: data_q, wr: wr_q, rd: rd_q, a15: a15_q};

endmodule

//--- xt_regs.sv
// system registers behind port xxAF and the 7FFD paging port with its locks
`include "zports_consts.svh"

module xt_regs (
	input  logic                   zclk,
	input  logic                   rst,
	input  zports_pkg::io_access_t acc,
	output zports_pkg::xt_page_t   xt_page,
	output zports_pkg::byte_t      sysconf,
	output zports_pkg::byte_t      memconf,
	output zports_pkg::byte_t      im2vect
);

	localparam zports_pkg::byte_t RAMPAGE_IDX = `XT_RAMPAGE;
	localparam zports_pkg::byte_t SYSCONF_IDX = `XT_SYSCONF;
	localparam zports_pkg::byte_t MEMCONF_IDX = `XT_MEMCONF;
	localparam zports_pkg::byte_t IM2VECT_IDX = `XT_IM2VECT;

	zports_pkg::page_t pages [4];

	logic lck48;   // set once by 7FFD bit 5, cleared only by reset
	logic lock128;
	logic xt_wr;
	logic p7ffd_wr;

	assign xt_wr    = acc.wr && (acc.port == zports_pkg::PORT_XT);
	assign p7ffd_wr = acc.wr && (acc.port == zports_pkg::PORT_7FFD) && !lck48;

	// 128K lock keeps page 3 inside the first 8 pages
	assign lock128 = memconf[6];

	always_ff @(posedge zclk)
	begin
		if (rst)
		begin
			lck48    <= 1'b0;
			sysconf  <= `SYSCONF_RST;
			memconf  <= `MEMCONF_RST;
			im2vect  <= `IM2VECT_RST;
			pages[0] <= `PAGE0_RST;
			pages[1] <= `PAGE1_RST;
			pages[2] <= `PAGE2_RST;
			pages[3] <= `PAGE3_RST;
		end
		else if (p7ffd_wr)
		begin
			pages[3]   <= {3'b000, lock128 ? 2'b00 : acc.data[7:6], acc.data[2:0]};
			memconf[0] <= acc.data[4]; // rom select
			lck48      <= acc.data[5];
		end
		else if (xt_wr)
		begin
			if (acc.xt_index[7:2] == RAMPAGE_IDX[7:2])
			begin
				pages[acc.xt_index[1:0]] <= acc.data;
			end
			if (acc.xt_index == SYSCONF_IDX)
			begin
				sysconf <= acc.data;
			end
			if (acc.xt_index == MEMCONF_IDX)
			begin
				memconf <= acc.data;
			end
			if (acc.xt_index == IM2VECT_IDX)
			begin
				im2vect <= acc.data;
			end
		end
	end

	assign xt_page = {pages[3], pages[2], pages[1], pages[0]};

endmodule

//--- sd_ports.sv
// SD card ports 77 and 57: chip select register, SPI start pulse and outgoing byte
module sd_ports (
	input  logic                   zclk,
	input  logic                   rst,
	input  zports_pkg::io_access_t acc,
	output logic                   sdcs_n,
	output logic                   sd_start,
	output zports_pkg::byte_t      sd_datain
);

	logic sdcfg_wr;
	logic sddat_hit;

	assign sdcfg_wr  = acc.wr && (acc.port == zports_pkg::PORT_SDCFG);
	assign sddat_hit = acc.port == zports_pkg::PORT_SDDAT;

	// chip select, deselected after reset
	always_ff @(posedge zclk)
	begin
		if (rst)
			sdcs_n <= 1'b1;
		else if (sdcfg_wr)
			sdcs_n <= acc.data[1];
	end

	// one SPI exchange per data port access
	assign sd_start = sddat_hit && (acc.wr || acc.rd);

	// a read clocks FF out to get the card's byte back
	assign sd_datain = acc.wr ? acc.data : 8'hFF;

endmodule

//--- port_read_mux.sv
// read side of the port block: read data selection, port hit decode and the power-up flag
`include "zports_consts.svh"

module port_read_mux (
	input  logic                   zclk,
	input  logic                   rst,
	input  zports_pkg::addr_t      a,
	input  zports_pkg::io_access_t acc,
	input  logic                   iord,
	input  logic [4:0]             keys_in,
	input  logic                   tape_read,
	input  logic                   dma_act,
	input  zports_pkg::byte_t      sd_dataout,
	input  zports_pkg::xt_page_t   xt_page,
	output zports_pkg::byte_t      dout,
	output logic                   dataout,
	output logic                   porthit
);

	zports_pkg::byte_t loa;
	zports_pkg::byte_t hoa;
	logic              pwr_up;
	logic              ext_port;

	assign loa = a[7:0];
	assign hoa = a[15:8];

	assign porthit = (loa == `PORT_FE) || (loa == `PORT_XT) || (loa == `PORT_FD)
		|| (loa == `PORT_SDCFG) || (loa == `PORT_SDDAT);

	assign ext_port = (loa == `PORT_FD) && a[15]; // AY owns the bus here
	assign dataout  = porthit && iord && !ext_port;

	// cleared by the first status read after reset
	always_ff @(posedge zclk)
	begin
		if (rst)
			pwr_up <= 1'b1;
		else if (acc.rd && (acc.port == zports_pkg::PORT_XT) && (acc.xt_index == `XT_XSTAT))
			pwr_up <= 1'b0;
	end

	always_comb
	begin
		case (loa)
			`PORT_FE:    dout = {1'b1, tape_read, 1'b0, keys_in};
			`PORT_XT:
			begin
				case (hoa)
					`XT_XSTAT:            dout = {1'b0, pwr_up, 6'b000000};
					`XT_DMASTAT:          dout = {dma_act, 7'b0000000};
					`XT_RAMPAGE + 8'd2:   dout = xt_page[23:16];
					`XT_RAMPAGE + 8'd3:   dout = xt_page[31:24];
					default:              dout = 8'hFF;
				endcase
			end
			`PORT_SDCFG: dout = 8'h00; // card always present, not write protected
			`PORT_SDDAT: dout = sd_dataout;
			default:     dout = 8'hFF;
		endcase
	end

endmodule

//--- zports_top.sv
// top of the port block, wires the bus access stage to the register, SD and read blocks
module zports_top (
	input  logic                 zclk,
	input  logic                 rst,

	input  zports_pkg::addr_t    a,
	input  zports_pkg::byte_t    din,
	input  logic                 iowr,
	input  logic                 iord,
	output zports_pkg::byte_t    dout,
	output logic                 dataout,
	output logic                 porthit,

	input  logic [4:0]           keys_in,   // port FE
	input  logic                 tape_read,
	input  logic                 dma_act,

	output zports_pkg::xt_page_t xt_page,
	output zports_pkg::byte_t    sysconf,
	output zports_pkg::byte_t    memconf,
	output zports_pkg::byte_t    im2vect,

	output logic                 sdcs_n,
	output logic                 sd_start,
	output zports_pkg::byte_t    sd_datain,
	input  zports_pkg::byte_t    sd_dataout
);

	zports_pkg::io_access_t acc;

	zbus_access u_access (
		.zclk (zclk),
		.rst  (rst),
		.a    (a),
		.din  (din),
		.iowr (iowr),
		.iord (iord),
		.acc  (acc)
	);

	xt_regs u_xt_regs (
		.zclk    (zclk),
		.rst     (rst),
		.acc     (acc),
		.xt_page (xt_page),
		.sysconf (sysconf),
		.memconf (memconf),
		.im2vect (im2vect)
	);

	sd_ports u_sd_ports (
		.zclk      (zclk),
		.rst       (rst),
		.acc       (acc),
		.sdcs_n    (sdcs_n),
		.sd_start  (sd_start),
		.sd_datain (sd_datain)
	);

	// read data follows the live address, not acc
	port_read_mux u_read_mux (
		.zclk       (zclk),
		.rst        (rst),
		.a          (a),
		.acc        (acc),
		.iord       (iord),
		.keys_in    (keys_in),
		.tape_read  (tape_read),
		.dma_act    (dma_act),
		.sd_dataout (sd_dataout),
		.xt_page    (xt_page),
		.dout       (dout),
		.dataout    (dataout),
		.porthit    (porthit)
	);

endmodule

//--- zports_properties.sv
// concurrent checks on the decoded access pulses, bound into the port block top level
`include "zports_consts.svh"

module zports_properties (
	input logic                   zclk,
	input logic                   rst,
	input zports_pkg::addr_t      a,
	input logic                   iowr,
	input logic                   iord,
	input zports_pkg::io_access_t acc,
	input logic                   sd_start
);
	timeunit 1ns;
	timeprecision 1ps;

	// an access is either a write or a read
	wr_rd_excl: assert property (@(posedge zclk) disable iff (rst) !(acc.wr && acc.rd))
		else $error("write and read pulses high in the same cycle");

	// one cycle per rise of the level, two edges after it is first sampled
	wr_single: assert property (@(posedge zclk) disable iff (rst)
		acc.wr |-> $past(iowr, 2) && !$past(iowr, 3))
		else $error("write pulse not tied to a single rise of iowr");

	rd_single: assert property (@(posedge zclk) disable iff (rst)
		acc.rd |-> $past(iord, 2) && !$past(iord, 3))
		else $error("read pulse not tied to a single rise of iord");

	// SPI start only from the data port
	start_port: assert property (@(posedge zclk) disable iff (rst)
		sd_start |-> $past(a[7:0]) == `PORT_SDDAT)
		else $error("sd_start without an access to port 57");

endmodule

bind zports_top zports_properties u_props (
	.zclk     (zclk),
	.rst      (rst),
	.a        (a),
	.iowr     (iowr),
	.iord     (iord),
	.acc      (acc),
	.sd_start (sd_start)
);

//--- tb_zports.sv
// directed testbench for the port block, drives the top level through bus cycles and checks outputs
`include "zports_consts.svh"

module tb_zports;
	timeunit 1ns;
	timeprecision 1ps;

	logic                 zclk;
	logic                 rst;
	zports_pkg::addr_t    a;
	zports_pkg::byte_t    din;
	logic                 iowr;
	logic                 iord;
	logic [4:0]           keys_in;
	logic                 tape_read;
	logic                 dma_act;
	zports_pkg::byte_t    sd_dataout;
	zports_pkg::byte_t    dout;
	logic                 dataout;
	logic                 porthit;
	zports_pkg::xt_page_t xt_page;
	zports_pkg::byte_t    sysconf;
	zports_pkg::byte_t    memconf;
	zports_pkg::byte_t    im2vect;
	logic                 sdcs_n;
	logic                 sd_start;
	zports_pkg::byte_t    sd_datain;

	int    errors;
	int    checks;
	int    tests;
	int    test_errs;
	string cur_test;

	zports_top UUT (.*);

	initial
	begin
		zclk = 1'b0;
		forever #20 zclk = ~zclk;
	end

	function automatic zports_pkg::byte_t rand_byte();
		logic [31:0] r;
		r = $urandom;
		return r[7:0];
	endfunction

	task automatic start_test(input string name);
		cur_test = name;
		test_errs = 0;
		tests++;
	endtask

	task automatic finish_test();
		$display("test %s done, %0d errors", cur_test, test_errs);
	endtask

	task automatic note_error();
		errors++;
		test_errs++;
	endtask

	task automatic check_byte(input string what, input zports_pkg::byte_t exp,
		input zports_pkg::byte_t act);
		checks++;
		if (act !== exp)
		begin
			note_error();
			$display("[FAIL] %s %s: expected %02h, actual %02h", cur_test, what, exp, act);
		end
	endtask

	task automatic check_page(input string what, input zports_pkg::xt_page_t exp,
		input zports_pkg::xt_page_t act);
		checks++;
		if (act !== exp)
		begin
			note_error();
			$display("[FAIL] %s %s: expected %08h, actual %08h", cur_test, what, exp, act);
		end
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		checks++;
		if (act !== exp)
		begin
			note_error();
			$display("[FAIL] %s %s: expected %b, actual %b", cur_test, what, exp, act);
		end
	endtask

	task automatic check_count(input string what, input int exp, input int act);
		checks++;
		if (act != exp)
		begin
			note_error();
			$display("[FAIL] %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
		end
	endtask

	task automatic abort_run(input string msg);
		$display("%s: %s", cur_test, msg);
		$display("Testbench failed");
		$finish;
	endtask

	// level held 3 cycles, then 2 idle cycles; entered and left 2 ns after a rising edge
	task automatic bus_cycle(input zports_pkg::addr_t addr, input zports_pkg::byte_t data,
		input logic rd, output zports_pkg::byte_t rdata);
		int n;
		a = addr;
		din = data;
		if (rd)
			iord = 1'b1;
		else
			iowr = 1'b1;
		n = 0;
		@(negedge zclk);
		while (!(rd ? UUT.acc.rd : UUT.acc.wr) && n < 100)
		begin
			@(negedge zclk);
			n++;
		end
		if (n >= 100)
			abort_run("no access pulse seen within 100 cycles");
		else
		begin
			rdata = dout; // stable mid-cycle while iord is high
			@(posedge zclk);
			#2;
			iowr = 1'b0;
			iord = 1'b0;
			repeat (2) @(posedge zclk);
			#2;
		end
	endtask

	task automatic io_write(input zports_pkg::addr_t addr, input zports_pkg::byte_t data);
		zports_pkg::byte_t unused;
		bus_cycle(addr, data, 1'b0, unused);
	endtask

	task automatic io_read(input zports_pkg::addr_t addr, output zports_pkg::byte_t rdata);
		bus_cycle(addr, 8'h00, 1'b1, rdata);
	endtask

	// one data port access, counting sd_start pulses over a 5-cycle window
	task automatic sd_access(input logic rd, input zports_pkg::byte_t data, output int cnt,
		output zports_pkg::byte_t seen, output zports_pkg::byte_t rdata);
		cnt = 0;
		seen = 8'h00;
		fork
			bus_cycle({8'h00, `PORT_SDDAT}, data, rd, rdata);
			repeat (5)
			begin
				@(negedge zclk);
				if (sd_start)
				begin
					cnt++;
					seen = sd_datain;
				end
			end
		join
	endtask

	task automatic test_reset_values();
		zports_pkg::byte_t r;
		start_test("reset_values");
		check_page("xt_page", {`PAGE3_RST, `PAGE2_RST, `PAGE1_RST, `PAGE0_RST}, xt_page);
		check_byte("sysconf", `SYSCONF_RST, sysconf);
		check_byte("memconf", `MEMCONF_RST, memconf);
		check_byte("im2vect", `IM2VECT_RST, im2vect);
		check_bit("sdcs_n", 1'b1, sdcs_n);
		io_read({`XT_XSTAT, `PORT_XT}, r);
		check_byte("first status read", 8'h40, r);
		io_read({`XT_XSTAT, `PORT_XT}, r);
		check_byte("second status read", 8'h00, r);
		finish_test();
	endtask

	task automatic test_xt_writes();
		zports_pkg::byte_t pg [4];
		zports_pkg::byte_t sc;
		zports_pkg::byte_t mc;
		zports_pkg::byte_t iv;
		zports_pkg::byte_t r;
		start_test("xt_writes");
		for (int i = 0; i < 4; i++)
		begin
			pg[i] = rand_byte();
			io_write({`XT_RAMPAGE + 8'(i), `PORT_XT}, pg[i]);
		end
		sc = rand_byte();
		mc = rand_byte();
		iv = rand_byte();
		io_write({`XT_SYSCONF, `PORT_XT}, sc);
		io_write({`XT_MEMCONF, `PORT_XT}, mc);
		io_write({`XT_IM2VECT, `PORT_XT}, iv);
		check_page("xt_page", {pg[3], pg[2], pg[1], pg[0]}, xt_page);
		check_byte("sysconf", sc, sysconf);
		check_byte("memconf", mc, memconf);
		check_byte("im2vect", iv, im2vect);
		io_read({`XT_RAMPAGE + 8'd2, `PORT_XT}, r);
		check_byte("read page 2", pg[2], r);
		io_read({`XT_RAMPAGE + 8'd3, `PORT_XT}, r);
		check_byte("read page 3", pg[3], r);
		dma_act = 1'b1;
		io_read({`XT_DMASTAT, `PORT_XT}, r);
		check_byte("dma status", 8'h80, r);
		dma_act = 1'b0;
		finish_test();
	endtask

	task automatic test_paging();
		zports_pkg::byte_t d;
		zports_pkg::byte_t mc;
		zports_pkg::byte_t pg3;
		start_test("paging_7ffd");
		mc = rand_byte() & 8'hBF; // 128K lock off
		io_write({`XT_MEMCONF, `PORT_XT}, mc);
		d = rand_byte() & 8'hDF;
		io_write(16'h7FFD, d);
		pg3 = {3'b000, d[7:6], d[2:0]};
		mc[0] = d[4];
		check_byte("page 3", pg3, xt_page[31:24]);
		check_byte("memconf", mc, memconf);
		io_write(16'hFFFD, rand_byte()); // AY address, not paging
		check_byte("page 3 after FFFD", pg3, xt_page[31:24]);
		check_byte("memconf after FFFD", mc, memconf);
		mc = mc | 8'h40;
		io_write({`XT_MEMCONF, `PORT_XT}, mc);
		d = (rand_byte() | 8'hC0) & 8'hDF;
		io_write(16'h7FFD, d);
		pg3 = {5'b00000, d[2:0]};
		mc[0] = d[4];
		check_byte("page 3 with 128K lock", pg3, xt_page[31:24]);
		check_byte("memconf with 128K lock", mc, memconf);
		d = rand_byte() | 8'h20;
		io_write(16'h7FFD, d);
		pg3 = {5'b00000, d[2:0]};
		mc[0] = d[4];
		check_byte("page 3 on locking write", pg3, xt_page[31:24]);
		io_write(16'h7FFD, ~d);
		check_byte("page 3 after lock", pg3, xt_page[31:24]);
		check_byte("memconf after lock", mc, memconf);
		finish_test();
	endtask

	task automatic test_sd_ports();
		zports_pkg::byte_t d;
		zports_pkg::byte_t seen;
		zports_pkg::byte_t r;
		int                cnt;
		start_test("sd_ports");
		d = rand_byte();
		io_write({8'h00, `PORT_SDCFG}, d);
		check_bit("sdcs_n", d[1], sdcs_n);
		d = d ^ 8'h02;
		io_write({8'h00, `PORT_SDCFG}, d);
		check_bit("sdcs_n toggled", d[1], sdcs_n);
		d = rand_byte();
		sd_access(1'b0, d, cnt, seen, r);
		check_count("start pulses on write", 1, cnt);
		check_byte("sd_datain on write", d, seen);
		sd_dataout = rand_byte();
		sd_access(1'b1, rand_byte(), cnt, seen, r);
		check_count("start pulses on read", 1, cnt);
		check_byte("sd_datain on read", 8'hFF, seen);
		check_byte("read 57", sd_dataout, r);
		io_read({8'h00, `PORT_SDCFG}, r);
		check_byte("read 77", 8'h00, r);
		finish_test();
	endtask

	task automatic test_fe_decode();
		zports_pkg::addr_t hits [6] = '{16'h00FE, 16'h00AF, 16'h7FFD,
			16'hFFFD, 16'h0077, 16'h0057};
		zports_pkg::byte_t k;
		zports_pkg::byte_t r;
		start_test("fe_decode");
		k = rand_byte();
		keys_in = k[4:0];
		k = rand_byte();
		tape_read = k[0];
		io_read({8'h00, `PORT_FE}, r);
		check_byte("read FE", {1'b1, tape_read, 1'b0, keys_in}, r);
		foreach (hits[i])
		begin
			a = hits[i];
			@(negedge zclk);
			check_bit($sformatf("porthit %04h", hits[i]), 1'b1, porthit);
			@(posedge zclk);
			#2;
		end
		a = 16'h1234;
		@(negedge zclk);
		check_bit("porthit 1234", 1'b0, porthit);
		@(posedge zclk);
		#2;
		a = 16'hFFFD;
		iord = 1'b1;
		@(negedge zclk);
		check_bit("dataout FFFD", 1'b0, dataout);
		@(posedge zclk);
		#2;
		a = {8'h00, `PORT_FE};
		@(negedge zclk);
		check_bit("dataout FE", 1'b1, dataout);
		@(posedge zclk);
		#2;
		iord = 1'b0;
		repeat (2) @(posedge zclk);
		#2;
		finish_test();
	endtask

	initial
	begin
		void'($urandom(2832));
		errors = 0;
		checks = 0;
		tests = 0;
		rst = 1'b1;
		a = '0;
		din = '0;
		iowr = 1'b0;
		iord = 1'b0;
		keys_in = '0;
		tape_read = 1'b0;
		dma_act = 1'b0;
		sd_dataout = '0;
		repeat (8) @(posedge zclk);
		#2;
		rst = 1'b0;
		test_reset_values();
		test_xt_writes();
		test_paging();
		test_sd_ports();
		test_fe_decode();
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

//--- sim.f
+incdir+.
zports_pkg.sv
zbus_access.sv
xt_regs.sv
sd_ports.sv
port_read_mux.sv
zports_top.sv
zports_properties.sv
tb_zports.sv

//--- Bender.yml
package:
  name: zports

sources:
  - include_dirs:
      - .
    files:
      - zports_pkg.sv
      - zbus_access.sv
      - xt_regs.sv
      - sd_ports.sv
      - port_read_mux.sv
      - zports_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - zports_properties.sv
      - tb_zports.sv
